// ==== pk_pkg.sv ====
// control panel shared definitions
// command byte, bit 7:5 select the command
//   000 ignored, 001 fn key (4:1 index, 0 value), 01x keys[5:0], 100 keys[10:6],
//   101 keys[15:11], 110 status request, 111 rotary position (3:0)
package pk_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [3:0] rot_pos_t;
	// wre_, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb
	typedef logic [10:0] rot_bus_t;

	typedef enum logic [3:0] {
		FN_START = 4'd0,
		FN_MODE  = 4'd1,
		FN_CLOCK = 4'd2,
		FN_STOPN = 4'd3,
		FN_STEP  = 4'd4,
		FN_FETCH = 4'd5,
		FN_STORE = 4'd6,
		FN_CYCLE = 4'd7,
		FN_LOAD  = 4'd8,
		FN_BIN   = 4'd9,
		FN_OPRQ  = 4'd10,
		FN_CLEAR = 4'd11
	} fn_key_t;

	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_FNKEY,
		CMD_KEYS_LO,
		CMD_KEYS_MID,
		CMD_KEYS_HI,
		CMD_STATUS,
		CMD_ROTARY
	} cmd_kind_t;

	// r0..r7, then IC AC AR IR SR RZ KB, last position doubles KB
	localparam rot_bus_t ROT_TABLE [16] = '{
		11'b10000000000, 11'b10010000000, 11'b10100000000, 11'b10110000000,
		11'b11000000000, 11'b11010000000, 11'b11100000000, 11'b11110000000,
		11'b00001000000, 11'b00000100000, 11'b00000010000, 11'b00000001000,
		11'b00000000100, 11'b00000000010, 11'b00000000001, 11'b00000000001
	};
	localparam rot_pos_t ROT_RESET_POS = 4'd1;

	// serial bit timing
	localparam int CLKS_PER_BIT = 16;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_cnt_t;
	localparam bit_cnt_t BIT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);
	// start bit center, minus the synchronizer delay
	localparam bit_cnt_t HALF_LOAD = bit_cnt_t'(CLKS_PER_BIT / 2 - 2);

	// momentary key pulse length
	localparam int PULSE_LEN = 4;
	typedef logic [$clog2(PULSE_LEN+1)-1:0] pulse_cnt_t;
	localparam pulse_cnt_t PULSE_LOAD = pulse_cnt_t'(PULSE_LEN);

endpackage

// ==== pk_if.sv ====
// control panel internal bundles
// decoded command strobe and panel status toward the report sender
`timescale 1ns/10ps

interface pk_cmd_if;
	logic valid;
	pk_pkg::cmd_kind_t kind;
	pk_pkg::fn_key_t fn_idx;
	logic fn_val;
	logic [5:0] field;
	pk_pkg::rot_pos_t pos;

	modport src (output valid, kind, fn_idx, fn_val, field, pos);
	modport dst (input valid, kind, fn_idx, fn_val, field, pos);
endinterface

interface pk_stat_if;
	logic mode;
	logic stop_n;
	logic zeg;
	pk_pkg::rot_pos_t rot_pos;

	modport src (output mode, stop_n, zeg, rot_pos);
	modport dst (input mode, stop_n, zeg, rot_pos);
endinterface

// ==== pk_uart.sv ====
// panel UART, 8N1 receiver and transmitter
// fixed bit time of CLKS_PER_BIT clocks
`timescale 1ns/10ps

module pk_uart (
	input  logic CLK_EXT,
	input  logic rst_n,
	input  logic rxd,
	output logic txd,
	output logic rx_valid,
	output pk_pkg::byte_t rx_byte,
	input  logic tx_start,
	input  pk_pkg::byte_t tx_byte,
	output logic tx_busy
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	logic [1:0] rx_sync;
	logic rx_s;
	rx_state_t rx_state;
	pk_pkg::bit_cnt_t rx_cnt;
	logic [2:0] rx_bit;
	pk_pkg::bit_cnt_t tx_cnt;
	logic [3:0] tx_left;
	logic [8:0] tx_shift;

	assign rx_s = rx_sync[1];

	always_ff @(posedge CLK_EXT) begin
		if (!rst_n)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], rxd};
	end

	always_ff @(posedge CLK_EXT) begin
		if (!rst_n) begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (rx_state != RX_IDLE && rx_cnt != '0)
				rx_cnt <= rx_cnt - 1'b1;
			case (rx_state)
				RX_IDLE: begin
					if (!rx_s) begin
						rx_state <= RX_START;
						rx_cnt <= pk_pkg::HALF_LOAD;
					end
				end
				RX_START: begin
					// glitch shorter than half a bit falls back to idle
					if (rx_cnt == '0) begin
						rx_state <= rx_s ? RX_IDLE : RX_DATA;
						rx_cnt <= pk_pkg::BIT_LAST;
						rx_bit <= '0;
					end
				end
				RX_DATA: begin
					if (rx_cnt == '0) begin
						rx_cnt <= pk_pkg::BIT_LAST;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default: begin
					// framing error drops the byte
					if (rx_cnt == '0) begin
						rx_valid <= rx_s;
						rx_state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge CLK_EXT) begin
		if (rx_state == RX_DATA && rx_cnt == '0)
			rx_byte <= {rx_s, rx_byte[7:1]};
	end

	always_ff @(posedge CLK_EXT) begin
		if (!rst_n) begin
			txd <= 1'b1;
			tx_busy <= 1'b0;
			tx_cnt <= '0;
			tx_left <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				txd <= 1'b0;
				tx_busy <= 1'b1;
				tx_cnt <= pk_pkg::BIT_LAST;
				tx_left <= 4'd9;
			end
		end else if (tx_cnt != '0) begin
			tx_cnt <= tx_cnt - 1'b1;
		end else if (tx_left == '0) begin
			tx_busy <= 1'b0;
		end else begin
			txd <= tx_shift[0];
			tx_cnt <= pk_pkg::BIT_LAST;
			tx_left <= tx_left - 1'b1;
		end
	end

	// data bits then stop bit
	always_ff @(posedge CLK_EXT) begin
		if (!tx_busy && tx_start)
			tx_shift <= {1'b1, tx_byte};
		else if (tx_busy && tx_cnt == '0)
			tx_shift <= {1'b1, tx_shift[8:1]};
	end

	a_tx_start_idle: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		tx_start |-> !tx_busy);

endmodule

// ==== pk_cmd_decode.sv ====
// command decoder, one typed strobe per received byte
`timescale 1ns/10ps

module pk_cmd_decode (
	input  logic CLK_EXT,
	input  logic rst_n,
	input  logic rx_valid,
	input  pk_pkg::byte_t rx_byte,
	pk_cmd_if.src cmd
);

	pk_pkg::cmd_kind_t kind;

	always_comb begin
		case (rx_byte[7:5])
			3'b001: kind = pk_pkg::CMD_FNKEY;
			3'b010,
			3'b011: kind = pk_pkg::CMD_KEYS_LO;
			3'b100: kind = pk_pkg::CMD_KEYS_MID;
			3'b101: kind = pk_pkg::CMD_KEYS_HI;
			3'b110: kind = pk_pkg::CMD_STATUS;
			3'b111: kind = pk_pkg::CMD_ROTARY;
			default: kind = pk_pkg::CMD_NONE;
		endcase
	end

	always_ff @(posedge CLK_EXT) begin
		if (!rst_n)
			cmd.valid <= 1'b0;
		else
			cmd.valid <= rx_valid && kind != pk_pkg::CMD_NONE;
	end

	// payload only meaningful with valid
	always_ff @(posedge CLK_EXT) begin
		if (rx_valid) begin
			cmd.kind <= kind;
			cmd.fn_idx <= pk_pkg::fn_key_t'(rx_byte[4:1]);
			cmd.fn_val <= rx_byte[0];
			cmd.field <= rx_byte[5:0];
			cmd.pos <= rx_byte[3:0];
		end
	end

	// serial bytes are at least a frame apart
	a_valid_single: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		cmd.valid |=> !cmd.valid);

endmodule

// ==== pk_panel_exec.sv ====
// panel state: data keys, function keys, rotary selector
// drives the latched controls, strobes and momentary pulses
`timescale 1ns/10ps

module pk_panel_exec (
	input  logic CLK_EXT,
	input  logic rst_n,
	pk_cmd_if.dst cmd,
	pk_stat_if.src stat,
	input  logic hlt_n_,
	input  logic p0_,
	output logic work,
	output logic start_s_,
	output logic stop_s_,
	output pk_pkg::word_t kl,
	output logic dcl_,
	output logic step_,
	output logic fetch_,
	output logic store_,
	output logic cycle_,
	output logic load_,
	output logic bin_,
	output logic oprq_,
	output pk_pkg::rot_bus_t rot_bus
);

	logic fn_cmd;
	logic start_k;
	logic mode_k;
	logic clock_k;
	logic stop_n_q;
	pk_pkg::rot_pos_t rot_pos_q;
	logic [7:0] pulse_on;

	assign fn_cmd = cmd.valid && cmd.kind == pk_pkg::CMD_FNKEY;

	always_ff @(posedge CLK_EXT) begin
		if (!rst_n) begin
			kl <= '0;
			rot_pos_q <= pk_pkg::ROT_RESET_POS;
			rot_bus <= pk_pkg::ROT_TABLE[pk_pkg::ROT_RESET_POS];
		end else if (cmd.valid) begin
			case (cmd.kind)
				pk_pkg::CMD_KEYS_LO: kl[5:0] <= cmd.field;
				pk_pkg::CMD_KEYS_MID: kl[10:6] <= cmd.field[4:0];
				pk_pkg::CMD_KEYS_HI: kl[15:11] <= cmd.field[4:0];
				pk_pkg::CMD_ROTARY: begin
					rot_pos_q <= cmd.pos;
					rot_bus <= pk_pkg::ROT_TABLE[cmd.pos];
				end
				default: ;
			endcase
		end
	end

	// latched keys and the start/stop edges
	always_ff @(posedge CLK_EXT) begin
		if (!rst_n) begin
			start_k <= 1'b0;
			mode_k <= 1'b0;
			clock_k <= 1'b0;
			start_s_ <= 1'b1;
			stop_s_ <= 1'b1;
		end else begin
			start_s_ <= !(fn_cmd && cmd.fn_idx == pk_pkg::FN_START && cmd.fn_val && !start_k);
			stop_s_ <= !(fn_cmd && cmd.fn_idx == pk_pkg::FN_START && !cmd.fn_val && start_k);
			if (fn_cmd && cmd.fn_idx == pk_pkg::FN_START)
				start_k <= cmd.fn_val;
			if (fn_cmd && cmd.fn_idx == pk_pkg::FN_MODE)
				mode_k <= cmd.fn_val;
			if (fn_cmd && cmd.fn_idx == pk_pkg::FN_CLOCK)
				clock_k <= cmd.fn_val;
		end
	end

	// halt from the CPU wins over a toggle
	always_ff @(posedge CLK_EXT) begin
		if (!rst_n || !hlt_n_)
			stop_n_q <= 1'b0;
		else if (fn_cmd && cmd.fn_idx == pk_pkg::FN_STOPN && cmd.fn_val)
			stop_n_q <= !stop_n_q;
	end

	// step..clear are keys 4..11, one counter each
	genvar g;
	for (g = 0; g < 8; g++) begin : g_pulse
		pk_pkg::pulse_cnt_t cnt;

		always_ff @(posedge CLK_EXT) begin
			if (!rst_n)
				cnt <= '0;
			else if (fn_cmd && cmd.fn_val && cmd.fn_idx == pk_pkg::fn_key_t'(g + 4))
				cnt <= pk_pkg::PULSE_LOAD;
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
		end

		assign pulse_on[g] = cnt != '0;
	end

	assign work = start_k;
	assign step_ = !pulse_on[0];
	assign fetch_ = !pulse_on[1] || p0_;
	assign store_ = !pulse_on[2] || p0_;
	assign cycle_ = !pulse_on[3] || p0_;
	assign load_ = !pulse_on[4] || p0_;
	assign bin_ = !pulse_on[5] || p0_;
	assign oprq_ = !pulse_on[6];
	assign dcl_ = !pulse_on[7];

	assign stat.mode = mode_k;
	assign stat.stop_n = stop_n_q;
	assign stat.zeg = clock_k;
	assign stat.rot_pos = rot_pos_q;

	a_rot_table: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		rot_bus == pk_pkg::ROT_TABLE[rot_pos_q]);

endmodule

// ==== pk_status_send.sv ====
// status report sender
// four bytes back to back: w high, w low, lamps, rotary and alarms
`timescale 1ns/10ps

module pk_status_send (
	input  logic CLK_EXT,
	input  logic rst_n,
	pk_cmd_if.dst cmd,
	pk_stat_if.dst stat,
	input  pk_pkg::word_t w,
	input  logic p_,
	input  logic mc_,
	input  logic alarm_,
	input  logic wait_,
	input  logic irq,
	input  logic q,
	input  logic run,
	input  logic tx_busy,
	output logic tx_start,
	output pk_pkg::byte_t tx_byte
);

	typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_WAIT_BUSY, ST_WAIT_DONE} st_t;

	st_t state;
	logic [1:0] b_cnt;
	pk_pkg::byte_t data;

	always_comb begin
		case (b_cnt)
			2'd0: data = w[15:8];
			2'd1: data = w[7:0];
			2'd2: data = {stat.mode, stat.stop_n, stat.zeg, q, !p_, !mc_, irq, run};
			default: data = {stat.rot_pos, 2'b00, !wait_, !alarm_};
		endcase
	end

	always_ff @(posedge CLK_EXT) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			b_cnt <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					b_cnt <= '0;
					if (cmd.valid && cmd.kind == pk_pkg::CMD_STATUS)
						state <= ST_SEND;
				end
				ST_SEND: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state <= ST_WAIT_BUSY;
					end
				end
				ST_WAIT_BUSY: begin
					if (tx_busy)
						state <= ST_WAIT_DONE;
				end
				default: begin
					if (!tx_busy) begin
						b_cnt <= b_cnt + 1'b1;
						state <= (b_cnt == 2'd3) ? ST_IDLE : ST_SEND;
					end
				end
			endcase
		end
	end

	// inputs captured as each byte goes out
	always_ff @(posedge CLK_EXT) begin
		if (state == ST_SEND && !tx_busy)
			tx_byte <= data;
	end

	a_start_pulse: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		tx_start |=> !tx_start);

	a_start_busy: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		tx_start |=> tx_busy);

endmodule

// ==== pk_panel_top.sv ====
// control panel serial front end, top level
`timescale 1ns/10ps

module pk_panel_top (
	input  logic CLK_EXT,
	input  logic rst_n,
	input  logic RXD,
	output logic TXD,
	input  logic hlt_n_,
	input  logic p0_,
	output logic work,
	output logic start_s_,
	output logic stop_s_,
	output logic mode,
	output logic stop_n,
	output logic zeg,
	output pk_pkg::word_t kl,
	output logic dcl_,
	output logic step_,
	output logic fetch_,
	output logic store_,
	output logic cycle_,
	output logic load_,
	output logic bin_,
	output logic oprq_,
	input  pk_pkg::word_t w,
	input  logic p_,
	input  logic mc_,
	input  logic alarm_,
	input  logic wait_,
	input  logic irq,
	input  logic q,
	input  logic run,
	output logic wre_,
	output logic rsa,
	output logic rsb,
	output logic rsc,
	output logic wic,
	output logic wac,
	output logic war,
	output logic wir,
	output logic wrs,
	output logic wrz,
	output logic wkb
);

	logic rx_valid;
	pk_pkg::byte_t rx_byte;
	logic tx_start;
	pk_pkg::byte_t tx_byte;
	logic tx_busy;
	pk_pkg::rot_bus_t rot_bus;

	pk_cmd_if cmd_if ();
	pk_stat_if stat_if ();

	pk_uart uart0 (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .rxd(RXD), .txd(TXD),
		.rx_valid(rx_valid), .rx_byte(rx_byte),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy)
	);

	pk_cmd_decode decode0 (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n),
		.rx_valid(rx_valid), .rx_byte(rx_byte), .cmd(cmd_if.src)
	);

	pk_panel_exec exec0 (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .cmd(cmd_if.dst), .stat(stat_if.src),
		.hlt_n_(hlt_n_), .p0_(p0_), .work(work), .start_s_(start_s_), .stop_s_(stop_s_),
		.kl(kl), .dcl_(dcl_), .step_(step_), .fetch_(fetch_), .store_(store_),
		.cycle_(cycle_), .load_(load_), .bin_(bin_), .oprq_(oprq_), .rot_bus(rot_bus)
	);

	pk_status_send send0 (
		.CLK_EXT(CLK_EXT), .rst_n(rst_n), .cmd(cmd_if.dst), .stat(stat_if.dst),
		.w(w), .p_(p_), .mc_(mc_), .alarm_(alarm_), .wait_(wait_), .irq(irq),
		.q(q), .run(run), .tx_busy(tx_busy), .tx_start(tx_start), .tx_byte(tx_byte)
	);

	assign mode = stat_if.mode;
	assign stop_n = stat_if.stop_n;
	assign zeg = stat_if.zeg;
	assign {wre_, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb} = rot_bus;

	// line idles high between frames
	a_txd_idle: assert property (@(posedge CLK_EXT) disable iff (!rst_n)
		!tx_busy |-> TXD);

endmodule

// ==== tb_clkgen.sv ====
// testbench clock and reset generator
// 100 ns clock, reset held low for the first 16 cycles
`timescale 1ns/10ps

module tb_clkgen (
	output logic CLK_EXT,
	output logic rst_n
);

	initial begin
		CLK_EXT = 1'b0;
		forever #50 CLK_EXT = ~CLK_EXT;
	end

	initial begin
		rst_n <= 1'b0;
		repeat (16) @(posedge CLK_EXT);
		rst_n <= 1'b1;
	end

endmodule

// ==== tb_pk_panel.sv ====
// testbench for the control panel serial front end
// sends commands on RXD, checks the CPU-side pins and the status report on TXD
`timescale 1ns/10ps

module tb_pk_panel;

	localparam int BIT_CLKS = pk_pkg::CLKS_PER_BIT;
	// one frame plus one idle bit time
	localparam int WINDOW = 11 * BIT_CLKS;
	localparam int MAX_CYCLES = 60000;

	logic CLK_EXT;
	logic rst_n;
	logic RXD;
	logic TXD;
	logic hlt_n_;
	logic p0_;
	pk_pkg::word_t w;
	logic p_, mc_, alarm_, wait_, irq, q, run;
	logic work, start_s_, stop_s_, mode, stop_n, zeg;
	pk_pkg::word_t kl;
	logic dcl_, step_, fetch_, store_, cycle_, load_, bin_, oprq_;
	logic wre_, rsa, rsb, rsc, wic, wac, war, wir, wrs, wrz, wkb;

	logic [9:0] low_pins;
	pk_pkg::rot_bus_t rot_pins;

	// model of the panel state
	pk_pkg::word_t m_kl;
	pk_pkg::rot_pos_t m_pos;
	logic m_work, m_mode, m_zeg, m_stop_n;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int rx_count = 0;
	pk_pkg::byte_t exp_q[$];
	int low_cnt[10];
	int exp_low[10];

	assign low_pins = {stop_s_, start_s_, dcl_, oprq_, bin_, load_, cycle_, store_, fetch_, step_};
	assign rot_pins = {wre_, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb};

	tb_clkgen clkgen0 (.CLK_EXT(CLK_EXT), .rst_n(rst_n));

	pk_panel_top dut0 (.*);

	// rotary select worked out from the panel coding
	function automatic pk_pkg::rot_bus_t rot_ref(input pk_pkg::rot_pos_t pos);
		pk_pkg::rot_bus_t r;
		r = '0;
		if (!pos[3])
			r = {1'b1, pos[2:0], 7'b0};
		else if (pos == 4'd15)
			r[0] = 1'b1;
		else
			r[4'd14 - pos] = 1'b1;
		return r;
	endfunction

	function automatic pk_pkg::byte_t status_ref(input int idx);
		case (idx)
			0: return w[15:8];
			1: return w[7:0];
			2: return {m_mode, m_stop_n, m_zeg, q, ~p_, ~mc_, irq, run};
			default: return {m_pos, 2'b00, ~wait_, ~alarm_};
		endcase
	endfunction

	// low cycles expected on a strobe or pulse pin for one command
	// pins 0..7 are keys 4..11, pin 8 start_s_, pin 9 stop_s_
	function automatic int low_ref(input int pin, input pk_pkg::byte_t b);
		int key;
		logic val;
		key = int'(b[4:1]);
		val = b[0];
		if (b[7:5] != 3'b001)
			return 0;
		if (pin == 8)
			return (key == 0 && val && !m_work) ? 1 : 0;
		if (pin == 9)
			return (key == 0 && !val && m_work) ? 1 : 0;
		if (key != pin + 4 || !val)
			return 0;
		// fetch..bin held off by p0_
		if (p0_ && pin >= 1 && pin <= 5)
			return 0;
		return pk_pkg::PULSE_LEN;
	endfunction

	function automatic void model_apply(input pk_pkg::byte_t b);
		case (b[7:5])
			3'b001: begin
				case (int'(b[4:1]))
					0: m_work = b[0];
					1: m_mode = b[0];
					2: m_zeg = b[0];
					3: begin
						if (b[0])
							m_stop_n = !m_stop_n;
					end
					default: ;
				endcase
			end
			3'b010, 3'b011: m_kl[5:0] = b[5:0];
			3'b100: m_kl[10:6] = b[4:0];
			3'b101: m_kl[15:11] = b[4:0];
			3'b111: m_pos = b[3:0];
			default: ;
		endcase
	endfunction

	function automatic pk_pkg::byte_t fn_byte(input int key, input logic val);
		return {3'b001, 4'(key), val};
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic check_state();
		check_val(32'(kl), 32'(m_kl), "data keys");
		check_val(32'(rot_pins), 32'(rot_ref(m_pos)), "rotary select");
		check_val(32'(work), 32'(m_work), "work");
		check_val(32'(mode), 32'(m_mode), "mode");
		check_val(32'(zeg), 32'(m_zeg), "clock enable");
		check_val(32'(stop_n), 32'(m_stop_n), "stop_n");
	endtask

	// 8N1, lsb first
	task automatic send_byte(input pk_pkg::byte_t b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge CLK_EXT);
			RXD <= frame[i];
			repeat (BIT_CLKS - 1) @(posedge CLK_EXT);
		end
	endtask

	task automatic count_lows();
		int p;
		for (p = 0; p < 10; p++)
			low_cnt[p] = 0;
		repeat (WINDOW) begin
			@(negedge CLK_EXT);
			for (p = 0; p < 10; p++)
				if (!low_pins[p])
					low_cnt[p]++;
		end
	endtask

	task automatic issue_cmd(input pk_pkg::byte_t b);
		int p;
		for (p = 0; p < 10; p++)
			exp_low[p] = low_ref(p, b);
		fork
			send_byte(b);
			count_lows();
		join
		for (p = 0; p < 10; p++)
			check_val(32'(low_cnt[p]), 32'(exp_low[p]),
				$sformatf("low cycles on pin %0d for command %h", p, b));
		model_apply(b);
		check_state();
	endtask

	task automatic request_status();
		int target;
		int k;
		@(posedge CLK_EXT);
		w <= pk_pkg::word_t'($urandom);
		{p_, mc_, alarm_, wait_, irq, q, run} <= 7'($urandom);
		@(posedge CLK_EXT);
		for (k = 0; k < 4; k++)
			exp_q.push_back(status_ref(k));
		target = rx_count + 4;
		issue_cmd(8'hc0);
		// lands while the first report is still on the line
		issue_cmd(8'hc0);
		while (rx_count < target)
			@(posedge CLK_EXT);
		repeat (3 * WINDOW) @(posedge CLK_EXT);
		check_val(32'(rx_count), 32'(target), "status bytes received");
		check_val(32'(exp_q.size()), 32'd0, "status bytes still expected");
	endtask

	// TXD frame receiver and status byte compare
	initial begin : rx_frames
		pk_pkg::byte_t b;
		int i;
		@(posedge rst_n);
		forever begin
			@(negedge CLK_EXT);
			if (!TXD) begin
				repeat (BIT_CLKS / 2) @(negedge CLK_EXT);
				for (i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge CLK_EXT);
					b[i] = TXD;
				end
				repeat (BIT_CLKS) @(negedge CLK_EXT);
				rx_count++;
				if (!TXD) begin
					errors++;
					$display("missing stop bit on TXD at %0t ns", $time);
				end else if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected byte %h on TXD at %0t ns", b, $time);
				end else begin
					check_val(32'(b), 32'(exp_q.pop_front()), "status byte");
				end
			end
		end
	end

	always @(posedge CLK_EXT) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, %0d errors so far", cycles, errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin : main
		pk_pkg::word_t kw;
		int i;
		RXD <= 1'b1;
		hlt_n_ <= 1'b1;
		p0_ <= 1'b0;
		w <= '0;
		{p_, mc_, alarm_, wait_, irq, q, run} <= 7'b1111000;
		m_kl = '0;
		m_pos = 4'd1;
		m_work = 1'b0;
		m_mode = 1'b0;
		m_zeg = 1'b0;
		m_stop_n = 1'b0;
		void'($urandom(32'h30bc));
		@(posedge rst_n);
		@(negedge CLK_EXT);
		check_state();
		check_val(32'(TXD), 32'd1, "TXD idle after reset");
		check_val(32'(low_pins), 32'h3ff, "active-low outputs after reset");

		for (i = 0; i < 20; i++) begin
			kw = pk_pkg::word_t'($urandom);
			issue_cmd({2'b01, kw[5:0]});
			issue_cmd({3'b100, kw[10:6]});
			issue_cmd({3'b101, kw[15:11]});
			check_val(32'(kl), 32'(kw), "key word");
		end
		// prefix 000 changes nothing
		issue_cmd(8'h1f);

		for (i = 0; i < 16; i++)
			issue_cmd({4'b1110, 4'(i)});

		request_status();

		for (i = 4; i < 12; i++)
			issue_cmd(fn_byte(i, 1'b1));
		@(posedge CLK_EXT);
		p0_ <= 1'b1;
		for (i = 4; i < 12; i++)
			issue_cmd(fn_byte(i, 1'b1));
		@(posedge CLK_EXT);
		p0_ <= 1'b0;

		issue_cmd(fn_byte(0, 1'b1));
		issue_cmd(fn_byte(0, 1'b0));
		issue_cmd(fn_byte(1, 1'b1));
		issue_cmd(fn_byte(2, 1'b1));
		issue_cmd(fn_byte(3, 1'b1));
		issue_cmd(fn_byte(3, 1'b1));
		issue_cmd(fn_byte(3, 1'b1));
		request_status();

		// halt from the CPU clears stop_n
		@(posedge CLK_EXT);
		hlt_n_ <= 1'b0;
		@(posedge CLK_EXT);
		hlt_n_ <= 1'b1;
		m_stop_n = 1'b0;
		@(negedge CLK_EXT);
		check_state();

		issue_cmd(fn_byte(1, 1'b0));
		issue_cmd(fn_byte(2, 1'b0));
		request_status();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
pk_pkg.sv
pk_if.sv
pk_uart.sv
pk_cmd_decode.sv
pk_panel_exec.sv
pk_status_send.sv
pk_panel_top.sv
tb_clkgen.sv
tb_pk_panel.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pk_panel \
	-f filelist.f -o tb_pk_panel_sim

./obj_dir/tb_pk_panel_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
